// File: logic/divSqrtPkg.sv
package divSqrtPkg;

  localparam int dataWidth = 32;  // lane operand width
  localparam int tagWidth  = 10;  // instruction index
  localparam int regWidth  = 9;   // destination register number
  localparam int numFwd    = 3;   // forwarding buses per lane
  localparam int csrWidth  = 32;

  // iteration counts of the lane engine
  localparam int rootWidth = dataWidth / 2;
  localparam int divSteps  = dataWidth;   // one quotient bit per cycle
  localparam int sqrtSteps = rootWidth;   // one root bit per cycle
  localparam int cntWidth  = $clog2(dataWidth);

  // exception flag positions
  localparam int flagWidth   = 2;
  localparam int flagDivZero = 0;
  localparam int flagInexact = 1;

  // the Lo/Hi suffix picks the result lane, both lanes always compute
  typedef enum logic [1:0] {
    opDivLo  = 2'd0,
    opSqrtLo = 2'd1,
    opDivHi  = 2'd2,
    opSqrtHi = 2'd3
  } fuOp_t;

  typedef enum logic [1:0] {
    fromReg  = 2'd0,  // register file value
    fromFwd0 = 2'd1,
    fromFwd1 = 2'd2,
    fromFwd2 = 2'd3
  } fwdSrc_t;

  typedef struct packed {
    fuOp_t               op;
    logic [tagWidth-1:0] tag;
    logic [regWidth-1:0] destReg;
  } issueReq_t;

  typedef struct packed {
    logic [dataWidth-1:0] value;  // quotient or zero-extended root
    logic [dataWidth-1:0] rem;
    logic                 divZero;
    logic                 inexact;
  } laneResult_t;

  // result port of the unit
  typedef struct packed {
    laneResult_t         res;
    logic [tagWidth-1:0] tag;
    logic [regWidth-1:0] destReg;
  } fuOut_t;

endpackage

// File: logic/operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
  input  logic [divSqrtPkg::dataWidth-1:0]                         regVal,
  input  logic [divSqrtPkg::numFwd-1:0][divSqrtPkg::dataWidth-1:0] fwdBus,
  input  divSqrtPkg::fwdSrc_t                                       sel,
  output logic [divSqrtPkg::dataWidth-1:0]                         operand
);
  import divSqrtPkg::*;

  // one copy per lane operand
  // a forwarded result bypasses the register file read
  always_comb begin
    case (sel)
      fromFwd0: operand = fwdBus[0];
      fromFwd1: operand = fwdBus[1];
      fromFwd2: operand = fwdBus[2];
      default:  operand = regVal;  // fromReg
    endcase
  end

endmodule

// File: logic/divSqrtLane.sv
`timescale 1ns/1ps

module divSqrtLane (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             start,
  input  logic                             isSqrt,
  input  logic                             flush,
  input  logic [divSqrtPkg::dataWidth-1:0] a,  // dividend or radicand
  input  logic [divSqrtPkg::dataWidth-1:0] b,  // divisor
  output logic                             done,
  output divSqrtPkg::laneResult_t          res
);
  import divSqrtPkg::*;

  typedef enum logic [1:0] {
    idle,
    run,
    finish
  } laneState_t;

  laneState_t state;
  logic [cntWidth-1:0] cnt;
  logic lastStep;

  logic sqrtMode;
  logic [dataWidth-1:0] divisor;
  logic [dataWidth-1:0] acc;  // partial remainder
  logic [dataWidth-1:0] quo;  // operand bits shift out at the top as quotient bits shift in
  logic [rootWidth-1:0] root;

  logic [dataWidth:0] divShift;
  logic [dataWidth:0] divDiff;
  logic divGe;
  logic [dataWidth-1:0] sqShift;
  logic [dataWidth-1:0] sqTrial;
  logic [dataWidth-1:0] sqDiff;
  logic sqGe;

  // restoring division step keeping acc below the divisor
  assign divShift = {acc, quo[dataWidth-1]};
  assign divDiff  = divShift - {1'b0, divisor};
  assign divGe    = divShift >= {1'b0, divisor};

  // square root step on the next pair of radicand bits
  assign sqShift = {acc[dataWidth-3:0], quo[dataWidth-1 -: 2]};
  assign sqTrial = {{(dataWidth - rootWidth - 2){1'b0}}, root, 2'b01};  // 4*root + 1
  assign sqDiff  = sqShift - sqTrial;
  assign sqGe    = sqShift >= sqTrial;

  assign lastStep = sqrtMode ? (cnt == cntWidth'(sqrtSteps - 1))
                             : (cnt == cntWidth'(divSteps - 1));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= idle;
      cnt   <= '0;
      done  <= 1'b0;
    end else if (flush) begin
      state <= idle;  // drop the operation without done
      cnt   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state <= run;
            cnt   <= '0;
          end
        end
        run: begin
          cnt <= cnt + 1'b1;
          if (lastStep) state <= finish;
        end
        finish: begin
          done  <= 1'b1;
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle: begin
        if (start) begin
          sqrtMode <= isSqrt;
          divisor  <= b;
          quo      <= a;
          acc      <= '0;
          root     <= '0;
        end
      end
      run: begin
        if (sqrtMode) begin
          acc  <= sqGe ? sqDiff : sqShift;
          quo  <= {quo[dataWidth-3:0], 2'b00};
          root <= {root[rootWidth-2:0], sqGe};
        end else begin
          acc <= divGe ? divDiff[dataWidth-1:0] : divShift[dataWidth-1:0];
          quo <= {quo[dataWidth-2:0], divGe};
        end
      end
      finish: begin
        // a zero divisor passes every trial so quo ends up all ones and acc holds the dividend
        if (sqrtMode) res.value <= {{(dataWidth - rootWidth){1'b0}}, root};
        else res.value <= quo;
        res.rem     <= acc;  // radicand minus root squared for sqrt
        res.divZero <= !sqrtMode && (divisor == '0);
        res.inexact <= acc != '0;
      end
      default: ;
    endcase
  end

endmodule

// File: logic/excFlags.sv
`timescale 1ns/1ps

module excFlags (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             valid,
  input  logic                             divZero,
  input  logic                             inexact,
  input  logic [divSqrtPkg::csrWidth-1:0]  csr,
  input  logic                             clearFlags,
  output logic [divSqrtPkg::flagWidth-1:0] flags,
  output logic                             trap
);
  import divSqrtPkg::*;

  logic [flagWidth-1:0] raised;
  logic [flagWidth-1:0] trapEn;

  always_comb begin
    raised              = '0;
    raised[flagDivZero] = valid & divZero;
    raised[flagInexact] = valid & inexact;
  end

  assign trapEn = csr[flagWidth-1:0];  // per-flag trap enables

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
      trap  <= 1'b0;
    end else begin
      if (clearFlags) flags <= '0;  // wins over a flag raised this cycle
      else flags <= flags | raised;
      trap <= |(raised & trapEn);
    end
  end

endmodule

// File: logic/divSqrtUnit.sv
`timescale 1ns/1ps

module divSqrtUnit (
  input  logic                                                     clk,
  input  logic                                                     rstN,
  input  logic                                                     issueEn,
  input  divSqrtPkg::issueReq_t                                     req,
  input  logic [divSqrtPkg::dataWidth-1:0]                         loA,
  input  logic [divSqrtPkg::dataWidth-1:0]                         loB,
  input  logic [divSqrtPkg::dataWidth-1:0]                         hiA,
  input  logic [divSqrtPkg::dataWidth-1:0]                         hiB,
  input  divSqrtPkg::fwdSrc_t                                       fwdLoA,
  input  divSqrtPkg::fwdSrc_t                                       fwdLoB,
  input  divSqrtPkg::fwdSrc_t                                       fwdHiA,
  input  divSqrtPkg::fwdSrc_t                                       fwdHiB,
  input  logic [divSqrtPkg::numFwd-1:0][divSqrtPkg::dataWidth-1:0] fwdBusLo,
  input  logic [divSqrtPkg::numFwd-1:0][divSqrtPkg::dataWidth-1:0] fwdBusHi,
  input  logic                                                     flush,
  input  logic [divSqrtPkg::csrWidth-1:0]                          csr,
  input  logic                                                     clearFlags,
  output logic                                                     pause,
  output logic                                                     outValid,
  output divSqrtPkg::fuOut_t                                        result,
  output logic [divSqrtPkg::flagWidth-1:0]                         flags,
  output logic                                                     trap
);
  import divSqrtPkg::*;

  typedef enum logic {
    idle,
    busy
  } unitState_t;

  unitState_t state;
  issueReq_t held;  // request in flight
  logic start;
  logic accept;
  logic finishNow;
  logic isSqrt;
  logic hiSel;

  logic [dataWidth-1:0] selLoA, selLoB, selHiA, selHiB;
  logic [dataWidth-1:0] opLoA, opLoB, opHiA, opHiB;

  logic doneLo;
  laneResult_t resLo, resHi, resSel;

  assign pause     = state == busy;
  assign accept    = issueEn && !pause && !flush;  // refused issues are not queued
  assign finishNow = (state == busy) && doneLo && !flush;
  assign isSqrt    = (held.op == opSqrtLo) || (held.op == opSqrtHi);
  assign hiSel     = (held.op == opDivHi) || (held.op == opSqrtHi);
  assign resSel    = hiSel ? resHi : resLo;

  operandSelect selLoAInst (.regVal(loA), .fwdBus(fwdBusLo), .sel(fwdLoA), .operand(selLoA));
  operandSelect selLoBInst (.regVal(loB), .fwdBus(fwdBusLo), .sel(fwdLoB), .operand(selLoB));
  operandSelect selHiAInst (.regVal(hiA), .fwdBus(fwdBusHi), .sel(fwdHiA), .operand(selHiA));
  operandSelect selHiBInst (.regVal(hiB), .fwdBus(fwdBusHi), .sel(fwdHiB), .operand(selHiB));

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= idle;
      start    <= 1'b0;
      outValid <= 1'b0;
    end else begin
      start    <= accept;
      outValid <= finishNow;
      case (state)
        idle: if (accept) state <= busy;
        busy: if (flush || outValid) state <= idle;  // pause held through the outValid cycle
        default: state <= idle;
      endcase
    end
  end

  // operands and tags captured at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      held  <= req;
      opLoA <= selLoA;
      opLoB <= selLoB;
      opHiA <= selHiA;
      opHiB <= selHiB;
    end
    if (finishNow) begin
      result.res     <= resSel;
      result.tag     <= held.tag;
      result.destReg <= held.destReg;
    end
  end

  divSqrtLane laneLo (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .isSqrt (isSqrt),
    .flush  (flush),
    .a      (opLoA),
    .b      (opLoB),
    .done   (doneLo),
    .res    (resLo)
  );

  divSqrtLane laneHi (
    .clk    (clk),
    .rstN   (rstN),
    .start  (start),
    .isSqrt (isSqrt),
    .flush  (flush),
    .a      (opHiA),
    .b      (opHiB),
    .done   (),  // runs in lockstep with laneLo
    .res    (resHi)
  );

  // fed ahead of the output register so flags and trap line up with outValid
  excFlags excFlagsInst (
    .clk        (clk),
    .rstN       (rstN),
    .valid      (finishNow),
    .divZero    (resSel.divZero),
    .inexact    (resSel.inexact),
    .csr        (csr),
    .clearFlags (clearFlags),
    .flags      (flags),
    .trap       (trap)
  );

endmodule

// File: bench/tbDivSqrt.sv
`timescale 1ns/1ps

module tbDivSqrt;
  import divSqrtPkg::*;

  localparam int waitLimit = 200;  // cycles per wait loop

  typedef logic [numFwd-1:0][dataWidth-1:0] fwdBus_t;

  typedef struct packed {
    fuOp_t                op;
    fwdSrc_t              srcLoA;
    fwdSrc_t              srcLoB;
    fwdSrc_t              srcHiA;
    fwdSrc_t              srcHiB;
    logic [dataWidth-1:0] loA;
    logic [dataWidth-1:0] loB;
    logic [dataWidth-1:0] hiA;
    logic [dataWidth-1:0] hiB;
    fwdBus_t              busLo;
    fwdBus_t              busHi;
    logic [csrWidth-1:0]  csr;
    logic [7:0]           flushAfter;  // 0 runs to completion
    logic                 clr;         // pulse clearFlags after the result
  } testRow_t;

  logic clk, rstN, issueEn, flush, clearFlags;
  issueReq_t req;
  logic [dataWidth-1:0] loA, loB, hiA, hiB;
  fwdSrc_t fwdLoA, fwdLoB, fwdHiA, fwdHiB;
  fwdBus_t fwdBusLo, fwdBusHi;
  logic [csrWidth-1:0] csr;
  logic pause, outValid, trap;
  fuOut_t result;
  logic [flagWidth-1:0] flags;

  testRow_t rows[$];
  logic [31:0] rngState;
  logic [flagWidth-1:0] expFlags;
  int errors, outCount, accepted;
  bit rowErr;

  divSqrtUnit DUT (
    .clk(clk), .rstN(rstN), .issueEn(issueEn), .req(req),
    .loA(loA), .loB(loB), .hiA(hiA), .hiB(hiB),
    .fwdLoA(fwdLoA), .fwdLoB(fwdLoB), .fwdHiA(fwdHiA), .fwdHiB(fwdHiB),
    .fwdBusLo(fwdBusLo), .fwdBusHi(fwdBusHi), .flush(flush), .csr(csr),
    .clearFlags(clearFlags), .pause(pause), .outValid(outValid), .result(result),
    .flags(flags), .trap(trap)
  );

  always #20 clk = ~clk;

  always @(negedge clk) if (rstN && outValid) outCount++;  // every result pulse

  function automatic logic [31:0] randWord();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // shifted down so quotients are not mostly zero
  function automatic logic [31:0] randDivisor();
    logic [31:0] w;
    logic [31:0] s;
    w = randWord();
    s = randWord();
    return w >> s[4:0];
  endfunction

  function automatic logic [dataWidth-1:0] pickOperand(input fwdSrc_t src,
      input logic [dataWidth-1:0] regVal, input fwdBus_t bus);
    if (src == fromReg) return regVal;
    return bus[int'(src) - 1];
  endfunction

  // integer quotient and remainder and a floor root found by bit trial on squares
  function automatic laneResult_t modelLane(input logic sqrtOp, input logic [31:0] a,
      input logic [31:0] b);
    laneResult_t r;
    logic [31:0] root;
    logic [31:0] trial;
    r = '0;
    if (sqrtOp) begin
      root = '0;
      for (int k = 15; k >= 0; k--) begin
        trial = root | (32'd1 << k);
        if (64'(trial) * 64'(trial) <= 64'(a)) root = trial;
      end
      r.value = root;
      r.rem   = a - root * root;
    end else if (b == 0) begin
      r.value   = '1;
      r.rem     = a;
      r.divZero = 1'b1;
    end else begin
      r.value = a / b;
      r.rem   = a % b;
    end
    r.inexact = r.rem != 0;
    return r;
  endfunction

  task automatic addRow(input fuOp_t op, input fwdSrc_t sLA, sLB, sHA, sHB,
      input logic [31:0] la, lb, ha, hb, input logic [31:0] csrVal,
      input int flushAfter, input logic clr);
    testRow_t row;
    row = '0;
    row.op = op;
    row.srcLoA = sLA;
    row.srcLoB = sLB;
    row.srcHiA = sHA;
    row.srcHiB = sHB;
    row.loA = la;
    row.loB = lb;
    row.hiA = ha;
    row.hiB = hb;
    row.csr = csrVal;
    row.flushAfter = 8'(flushAfter);
    row.clr = clr;
    for (int k = 0; k < numFwd; k++) begin
      row.busLo[k] = randDivisor();
      row.busHi[k] = randDivisor();
    end
    rows.push_back(row);
  endtask

  task automatic buildTable();
    for (int k = 0; k < 8; k++) begin  // random divisions
      addRow((k % 2) ? opDivHi : opDivLo, fromReg, fromReg, fromReg, fromReg,
             randWord(), randDivisor(), randWord(), randDivisor(), 0, 0, 0);
    end
    addRow(opSqrtLo, fromReg, fromReg, fromReg, fromReg, 0, 0, 32'hffff_ffff, 0, 0, 0, 0);
    addRow(opSqrtHi, fromReg, fromReg, fromReg, fromReg, 15, 0, 16, 0, 0, 0, 0);
    addRow(opSqrtLo, fromReg, fromReg, fromReg, fromReg, 1, 0, 32'h8000_0000, 0, 0, 0, 0);
    addRow(opSqrtHi, fromReg, fromReg, fromReg, fromReg, 32'h8000_0000, 0, 32'hffff_ffff, 0,
           0, 0, 0);
    for (int k = 0; k < 4; k++) begin
      addRow((k % 2) ? opSqrtHi : opSqrtLo, fromReg, fromReg, fromReg, fromReg,
             randWord(), randWord(), randWord(), randWord(), 0, 0, 0);
    end
    for (int s = 0; s < 4; s++) begin  // every source on A and B of both lanes
      addRow(opDivLo, fwdSrc_t'(s), fwdSrc_t'((s + 1) % 4), fwdSrc_t'((s + 2) % 4),
             fwdSrc_t'((s + 3) % 4), randWord(), randDivisor(), randWord(), randDivisor(),
             0, 0, 0);
      addRow(opDivHi, fwdSrc_t'((s + 2) % 4), fwdSrc_t'((s + 3) % 4), fwdSrc_t'(s),
             fwdSrc_t'((s + 1) % 4), randWord(), randDivisor(), randWord(), randDivisor(),
             0, 0, 0);
    end
    // zero divisor under trap enables 2 then 1 with a flag clear then 3 on the other lane
    addRow(opDivLo, fromReg, fromReg, fromReg, fromReg, 0, 0, 77, 7, 2, 0, 0);
    addRow(opDivHi, fromReg, fromReg, fromReg, fromReg, 50, 5, 32'h00ab_cdef, 0, 1, 0, 1);
    addRow(opDivLo, fromReg, fromReg, fromReg, fromReg, 100, 10, 9, 0, 3, 0, 0);
    // flush early and at the last cycle with a normal issue after each
    addRow(opSqrtHi, fromReg, fromReg, fromReg, fromReg, randWord(), 0, randWord(), 0,
           0, 6, 0);
    addRow(opDivLo, fromReg, fromReg, fromReg, fromReg, 1000, 3, 5, 2, 0, 0, 0);
    addRow(opDivHi, fromReg, fromReg, fromReg, fromReg, 999, 4, 12345, 6, 0, 34, 0);
    addRow(opSqrtLo, fromReg, fromReg, fromReg, fromReg, 144, 0, 10, 0, 0, 0, 0);
  endtask

  task automatic timeoutFail(input string what);
    $display("timeout waiting for result (%s)", what);
    $display("Errors found");
    $finish;
  endtask

  task automatic waitIdle();
    int n;
    n = 0;
    @(negedge clk);
    while (pause && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (pause) timeoutFail("pause low");
  endtask

  task automatic waitResult();
    int n;
    n = 0;
    @(negedge clk);
    while (!outValid && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!outValid) timeoutFail("outValid");
  endtask

  task automatic checkWord(input string what, input logic [31:0] got, exp, input int idx);
    assert (got === exp) else begin
      $display("mismatch at %0t: test %0d %s is %h, expected %h", $time, idx, what, got, exp);
      errors++;
      rowErr = 1'b1;
    end
  endtask

  task automatic runRow(input int idx, input testRow_t row);
    issueReq_t r;
    laneResult_t expLo, expHi, expSel;
    logic [flagWidth-1:0] raised;
    logic isSq, hi;
    r.op = row.op;
    r.tag = tagWidth'(idx + 'h40);
    r.destReg = regWidth'(idx * 7);
    isSq = (row.op == opSqrtLo) || (row.op == opSqrtHi);
    hi = (row.op == opDivHi) || (row.op == opSqrtHi);
    rowErr = 1'b0;
    waitIdle();
    @(posedge clk);
    issueEn <= 1'b1;
    req <= r;
    loA <= row.loA;
    loB <= row.loB;
    hiA <= row.hiA;
    hiB <= row.hiB;
    fwdLoA <= row.srcLoA;
    fwdLoB <= row.srcLoB;
    fwdHiA <= row.srcHiA;
    fwdHiB <= row.srcHiB;
    fwdBusLo <= row.busLo;
    fwdBusHi <= row.busHi;
    csr <= row.csr;
    @(posedge clk);  // accepted on this edge
    req.tag <= ~r.tag;  // retries while paused must be refused
    loA <= ~row.loA;
    repeat (3) @(posedge clk);
    issueEn <= 1'b0;
    if (row.flushAfter != 0) begin
      repeat (int'(row.flushAfter) - 3) @(posedge clk);
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
      @(negedge clk);
      assert (!pause) else begin
        $display("test %0d: pause did not drop after flush", idx);
        errors++;
        rowErr = 1'b1;
      end
      for (int n = 0; n < 40; n++) begin
        checkWord("outValid after flush", 32'(outValid), 0, idx);
        @(negedge clk);
      end
      $display("test %0d %s flushed: %s", idx, row.op.name(), rowErr ? "failed" : "ok");
    end else begin
      accepted++;
      waitResult();
      expLo = modelLane(isSq, pickOperand(row.srcLoA, row.loA, row.busLo),
                        pickOperand(row.srcLoB, row.loB, row.busLo));
      expHi = modelLane(isSq, pickOperand(row.srcHiA, row.hiA, row.busHi),
                        pickOperand(row.srcHiB, row.hiB, row.busHi));
      expSel = hi ? expHi : expLo;
      raised = '0;
      raised[flagDivZero] = expSel.divZero;
      raised[flagInexact] = expSel.inexact;
      expFlags = expFlags | raised;
      checkWord("value", result.res.value, expSel.value, idx);
      checkWord("rem", result.res.rem, expSel.rem, idx);
      checkWord("divZero", 32'(result.res.divZero), 32'(expSel.divZero), idx);
      checkWord("inexact", 32'(result.res.inexact), 32'(expSel.inexact), idx);
      checkWord("tag", 32'(result.tag), 32'(r.tag), idx);
      checkWord("destReg", 32'(result.destReg), 32'(r.destReg), idx);
      checkWord("flags", 32'(flags), 32'(expFlags), idx);
      checkWord("trap", 32'(trap), 32'(|(raised & row.csr[flagWidth-1:0])), idx);
      if (row.clr) begin
        @(posedge clk);
        clearFlags <= 1'b1;
        @(posedge clk);
        clearFlags <= 1'b0;
        @(negedge clk);
        expFlags = '0;
        checkWord("flags after clear", 32'(flags), 0, idx);
      end
      $display("test %0d %s: %s", idx, row.op.name(), rowErr ? "failed" : "ok");
    end
  endtask

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    issueEn = 1'b0;
    req = '0;
    loA = '0;
    loB = '0;
    hiA = '0;
    hiB = '0;
    fwdLoA = fromReg;
    fwdLoB = fromReg;
    fwdHiA = fromReg;
    fwdHiB = fromReg;
    fwdBusLo = '0;
    fwdBusHi = '0;
    flush = 1'b0;
    csr = '0;
    clearFlags = 1'b0;
    errors = 0;
    outCount = 0;
    accepted = 0;
    expFlags = '0;
    rngState = 32'h4917_62cb;
    buildTable();
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    assert (!outValid && !pause && !trap && flags == '0) else begin
      $display("outputs not cleared by reset");
      errors++;
    end
    foreach (rows[i]) runRow(i, rows[i]);
    waitIdle();
    repeat (3) @(negedge clk);
    checkWord("result count", 32'(outCount), 32'(accepted), -1);
    $display("tests %0d, failed checks %0d, results %0d, accepted issues %0d",
             rows.size(), errors, outCount, accepted);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: div_sqrt_unit

sources:
  - files:
      - logic/divSqrtPkg.sv
      - logic/operandSelect.sv
      - logic/divSqrtLane.sv
      - logic/excFlags.sv
      - logic/divSqrtUnit.sv
  - target: test
    files:
      - bench/tbDivSqrt.sv

// File: src.f
logic/divSqrtPkg.sv
logic/operandSelect.sv
logic/divSqrtLane.sv
logic/excFlags.sv
logic/divSqrtUnit.sv
bench/tbDivSqrt.sv
